// ==== include/loadUnit_consts.svh ====
`ifndef LOAD_UNIT_CONSTS_SVH
`define LOAD_UNIT_CONSTS_SVH

// Number of load result buffer entries
`define LRB_SIZE 8

// Line forwarding beat width in bits
`define AXI_WIDTH 64

// Age is compared by signed difference
`define SQN_WIDTH 7
`define TAG_WIDTH 7

`endif

// ==== hdl/loadPkg.sv ====
`include "loadUnit_consts.svh"

package loadPkg;

    // Raw load word, picked apart by byte or by halfword
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } LoadWord;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            addr;
        // 0 byte, 1 half, 2 word
        logic [1:0]             size;
        logic                   sext;
        logic                   dataAvail;
        LoadWord                data;
        // Bytes already supplied by store forwarding
        logic [3:0]             fwdMask;
        logic                   external;
        logic [`TAG_WIDTH-1:0]  tagDst;
        logic [`SQN_WIDTH-1:0]  sqN;
        logic                   doNotCommit;
    } LoadResUOp;

    // Line beat from the memory controller
    typedef struct packed {
        logic                   valid;
        logic [31:0]            addr;
        logic [`AXI_WIDTH-1:0]  data;
    } LineFwd;

    typedef struct packed {
        logic                   taken;
        logic [`SQN_WIDTH-1:0]  sqN;
    } BranchProv;

endpackage

// ==== hdl/loadSelIf.sv ====
`timescale 1ns/1ps
`include "loadUnit_consts.svh"

interface loadSelIf;
    import loadPkg::*;

    logic                   valid;
    LoadWord                data;
    logic [1:0]             addrLow;
    logic [1:0]             size;
    logic                   sext;
    logic [`TAG_WIDTH-1:0]  tagDst;
    logic [`SQN_WIDTH-1:0]  sqN;
    logic                   doNotCommit;

    // Buffer side
    modport source (output valid, data, addrLow, size, sext, tagDst, sqN, doNotCommit);

    // Aligner side
    modport sink (input valid, data, addrLow, size, sext, tagDst, sqN, doNotCommit);

endinterface

// ==== hdl/priorityEncoder.sv ====
`timescale 1ns/1ps

module priorityEncoder #(
    parameter int width = 8
) (
    input  logic [width-1:0]         request,
    output logic [$clog2(width)-1:0] idx,
    output logic                     found
);

    // Scan downwards so the lowest set bit is written last
    always_comb begin
        idx = '0;
        found = 1'b0;
        for (int i = width - 1; i >= 0; i--) begin
            if (request[i]) begin
                idx = ($clog2(width))'(i);
                found = 1'b1;
            end
        end
    end

endmodule

// ==== hdl/lineSnoop.sv ====
`timescale 1ns/1ps
`include "loadUnit_consts.svh"

module lineSnoop (
    input  loadPkg::LoadResUOp entry,
    input  loadPkg::LineFwd    fwd,
    output logic               hit,
    output loadPkg::LoadWord   mergedData
);

    // Byte offset bits inside one beat
    localparam int offBits = $clog2(`AXI_WIDTH / 8);

    logic lineMatch;

    assign lineMatch = entry.addr[31:offBits] == fwd.addr[31:offBits];

    // Only a waiting entry can be completed by a beat
    assign hit = entry.valid && !entry.dataAvail && fwd.valid && lineMatch;

    always_comb begin
        logic [offBits-1:0] beatIdx;

        mergedData = entry.data;
        for (int j = 0; j < 4; j++) begin
            beatIdx = {entry.addr[offBits-1:2], 2'(j)};
            // Store-forwarded bytes win over the line
            if (!entry.fwdMask[j]) begin
                mergedData.bytes[j] = fwd.data[beatIdx * 8 +: 8];
            end
        end
    end

endmodule

// ==== hdl/loadResultBuffer.sv ====
`timescale 1ns/1ps
`include "loadUnit_consts.svh"

module loadResultBuffer (
    input  logic                clk,
    input  logic                rst,
    input  loadPkg::BranchProv  branch,
    input  loadPkg::LineFwd     fwd,
    input  loadPkg::LoadResUOp  inUop,
    output logic                ready,
    input  logic                resReady,
    loadSelIf.source            sel
);
    import loadPkg::*;

    localparam int idxBits = $clog2(`LRB_SIZE);

    LoadResUOp            entries [`LRB_SIZE];
    LoadWord              snoopData [`LRB_SIZE];
    logic [`LRB_SIZE-1:0] snoopHit;
    logic [`LRB_SIZE-1:0] entryFree;
    logic [`LRB_SIZE-1:0] entryReady;

    logic [idxBits-1:0]   freeIdx;
    logic [idxBits-1:0]   readyIdx;
    logic                 freeFound;
    logic                 readyFound;

    LoadResUOp            outUop;
    logic                 inSquashed;
    logic                 deq;
    logic                 bypass;
    logic                 enqValid;

    // Younger non-external loads die on a taken branch
    function automatic logic isSquashed(LoadResUOp u, BranchProv b);
        return b.taken && !u.external && $signed(u.sqN - b.sqN) > 0;
    endfunction

    always_comb begin
        for (int i = 0; i < `LRB_SIZE; i++) begin
            entryFree[i] = !entries[i].valid;
            entryReady[i] = entries[i].valid && entries[i].dataAvail &&
                            !isSquashed(entries[i], branch);
        end
    end

    priorityEncoder #(.width(`LRB_SIZE)) freeEnc (
        .request (entryFree),
        .idx     (freeIdx),
        .found   (freeFound)
    );

    priorityEncoder #(.width(`LRB_SIZE)) readyEnc (
        .request (entryReady),
        .idx     (readyIdx),
        .found   (readyFound)
    );

    for (genvar i = 0; i < `LRB_SIZE; i++) begin : snoopGen
        lineSnoop snoop (
            .entry      (entries[i]),
            .fwd        (fwd),
            .hit        (snoopHit[i]),
            .mergedData (snoopData[i])
        );
    end

    assign ready = freeFound;

    // Stored loads go first, an incoming one only bypasses when none is ready
    always_comb begin
        inSquashed = isSquashed(inUop, branch);
        deq = resReady && readyFound;
        bypass = resReady && !readyFound && inUop.valid && inUop.dataAvail && !inSquashed;
        enqValid = inUop.valid && !bypass && !inSquashed && freeFound;
        outUop = deq ? entries[readyIdx] : inUop;
    end

    assign sel.valid = deq || bypass;
    assign sel.data = outUop.data;
    assign sel.addrLow = outUop.addr[1:0];
    assign sel.size = outUop.size;
    assign sel.sext = outUop.sext;
    assign sel.tagDst = outUop.tagDst;
    assign sel.sqN = outUop.sqN;
    assign sel.doNotCommit = outUop.doNotCommit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `LRB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `LRB_SIZE; i++) begin
                if (snoopHit[i]) begin
                    entries[i].data <= snoopData[i];
                    entries[i].dataAvail <= 1'b1;
                end
            end

            if (deq) begin
                entries[readyIdx].valid <= 1'b0;
            end

            // Free index is never the dequeued or a snooped entry
            if (enqValid) begin
                entries[freeIdx] <= inUop;
            end

            // Only live entries, a freed slot may be taking a new load
            for (int i = 0; i < `LRB_SIZE; i++) begin
                if (entries[i].valid && isSquashed(entries[i], branch)) begin
                    entries[i].valid <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hdl/loadAligner.sv ====
`timescale 1ns/1ps
`include "loadUnit_consts.svh"

module loadAligner (
    input  logic                  clk,
    input  logic                  rst,
    loadSelIf.sink                sel,
    output logic                  resValid,
    output logic [31:0]           resResult,
    output logic [`TAG_WIDTH-1:0] resTagDst,
    output logic                  resDoNotCommit,
    output logic                  flagsValid,
    output logic [`TAG_WIDTH-1:0] flagsTagDst,
    output logic [`SQN_WIDTH-1:0] flagsSqN,
    output logic                  flagsDoNotCommit
);

    logic [31:0] resultNext;

    // Flags leave in the select cycle
    assign flagsValid = sel.valid;
    assign flagsTagDst = sel.tagDst;
    assign flagsSqN = sel.sqN;
    assign flagsDoNotCommit = sel.doNotCommit;

    always_comb begin
        logic [7:0]  pickByte;
        logic [15:0] pickHalf;

        pickByte = sel.data.bytes[sel.addrLow];
        pickHalf = sel.data.halves[sel.addrLow[1]];
        case (sel.size)
            2'd0: resultNext = {{24{sel.sext & pickByte[7]}}, pickByte};
            2'd1: resultNext = {{16{sel.sext & pickHalf[15]}}, pickHalf};
            2'd2: resultNext = sel.data;
            // Size 3 never issues
            default: resultNext = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= sel.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel.valid) begin
            resResult <= resultNext;
            resTagDst <= sel.tagDst;
            resDoNotCommit <= sel.doNotCommit;
        end
    end

endmodule

// ==== hdl/loadResultUnit.sv ====
`timescale 1ns/1ps
`include "loadUnit_consts.svh"

module loadResultUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  branchTaken,
    input  logic [`SQN_WIDTH-1:0] branchSqN,
    input  logic                  fwdValid,
    input  logic [31:0]           fwdAddr,
    input  logic [`AXI_WIDTH-1:0] fwdData,
    input  logic                  inValid,
    input  logic [31:0]           inAddr,
    input  logic [1:0]            inSize,
    input  logic                  inSext,
    input  logic                  inDataAvail,
    input  logic [31:0]           inData,
    input  logic [3:0]            inFwdMask,
    input  logic                  inExternal,
    input  logic [`TAG_WIDTH-1:0] inTagDst,
    input  logic [`SQN_WIDTH-1:0] inSqN,
    input  logic                  inDoNotCommit,
    output logic                  ready,
    input  logic                  resReady,
    output logic                  resValid,
    output logic [31:0]           resResult,
    output logic [`TAG_WIDTH-1:0] resTagDst,
    output logic                  resDoNotCommit,
    output logic                  flagsValid,
    output logic [`TAG_WIDTH-1:0] flagsTagDst,
    output logic [`SQN_WIDTH-1:0] flagsSqN,
    output logic                  flagsDoNotCommit
);
    import loadPkg::*;

    BranchProv branch;
    LineFwd    fwd;
    LoadResUOp inUop;

    assign branch = '{taken: branchTaken, sqN: branchSqN};
    assign fwd = '{valid: fwdValid, addr: fwdAddr, data: fwdData};
    assign inUop = '{valid: inValid, addr: inAddr, size: inSize, sext: inSext,
                     dataAvail: inDataAvail, data: inData, fwdMask: inFwdMask,
                     external: inExternal, tagDst: inTagDst, sqN: inSqN,
                     doNotCommit: inDoNotCommit};

    loadSelIf selBus ();

    loadResultBuffer buffer (
        .clk      (clk),
        .rst      (rst),
        .branch   (branch),
        .fwd      (fwd),
        .inUop    (inUop),
        .ready    (ready),
        .resReady (resReady),
        .sel      (selBus.source)
    );

    loadAligner aligner (
        .clk              (clk),
        .rst              (rst),
        .sel              (selBus.sink),
        .resValid         (resValid),
        .resResult        (resResult),
        .resTagDst        (resTagDst),
        .resDoNotCommit   (resDoNotCommit),
        .flagsValid       (flagsValid),
        .flagsTagDst      (flagsTagDst),
        .flagsSqN         (flagsSqN),
        .flagsDoNotCommit (flagsDoNotCommit)
    );

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

// ==== test/loadResultUnitTb.sv ====
`timescale 1ns/1ps
`include "loadUnit_consts.svh"

module loadResultUnitTb;

    localparam int tagWaiting = 1;
    localparam int tagLive = 2;
    localparam int tagSquashed = 3;

    // Sequence numbers run ahead of tags and wrap past zero
    localparam int sqNBase = 100;

    // One row per cycle where -1 marks an unused field and expFlag -2 means don't care
    typedef struct packed {
        int          tag;
        logic [31:0] addr;
        int          size;
        bit          sext;
        bit          avail;
        logic [3:0]  mask;
        bit          ext;
        int          beatAddr;
        int          brSqN;
        bit          resRdy;
        int          expReady;
        int          expFlag;
    } Row;

    logic                  clk;
    logic                  rst;
    logic                  branchTaken, fwdValid, inValid, inSext, inDataAvail;
    logic                  inExternal, inDoNotCommit, ready, resReady, resValid;
    logic                  resDoNotCommit, flagsValid, flagsDoNotCommit;
    logic [1:0]            inSize;
    logic [3:0]            inFwdMask;
    logic [31:0]           fwdAddr, inAddr, inData, resResult;
    logic [`AXI_WIDTH-1:0] fwdData;
    logic [`SQN_WIDTH-1:0] branchSqN, inSqN, flagsSqN;
    logic [`TAG_WIDTH-1:0] inTagDst, resTagDst, flagsTagDst;

    Row          rows[$];
    Row          tagRow [128];
    int          tagState [128];
    bit          flagsSeen [128];
    bit          resSeen [128];
    bit          tagDnc [128];
    logic [31:0] tagData [128];
    logic [31:0] expRes [128];
    bit          tableReady;
    bit          flagsPending;
    int          pendTag;

    clockGen clockSource (.clk(clk));

    loadResultUnit UUT (.*);

    task automatic failRun(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compareValue(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] alignExpect(logic [31:0] word, logic [1:0] low,
                                                int size, bit sext);
        logic [7:0]  b;
        logic [15:0] h;

        b = 8'(word >> (8 * low));
        h = 16'(word >> (16 * low[1]));
        case (size)
            0: return sext ? 32'($signed(b)) : 32'(b);
            1: return sext ? 32'($signed(h)) : 32'(h);
            2: return word;
            default: return 0;
        endcase
    endfunction

    function automatic logic [31:0] mergeBeat(logic [31:0] held, logic [3:0] mask,
                                              logic upper, logic [63:0] beat);
        logic [31:0] half;
        logic [31:0] merged;

        half = upper ? beat[63:32] : beat[31:0];
        merged = held;
        for (int j = 0; j < 4; j++) begin
            if (!mask[j]) merged[8 * j +: 8] = half[8 * j +: 8];
        end
        return merged;
    endfunction

    function automatic bit isYounger(int sqN, int brSqN);
        logic [`SQN_WIDTH-1:0] diff;

        diff = sqN - brSqN;
        return diff != 0 && !diff[`SQN_WIDTH-1];
    endfunction

    function automatic Row idleRow(bit resRdy);
        return '{-1, 0, 0, 0, 0, 0, 0, -1, -1, resRdy, -1, -2};
    endfunction

    // Row fields in order are tag addr size sext avail mask ext beatAddr brSqN resRdy
    // expReady expFlag
    task automatic buildTable();
        logic [1:0] low;

        rows.push_back('{1, 'h100, 0, 0, 1, 0, 0, -1, -1, 1, 1, 1});
        rows.push_back('{2, 'h101, 0, 1, 1, 0, 0, -1, -1, 1, 1, 2});
        rows.push_back('{3, 'h103, 0, 1, 1, 0, 0, -1, -1, 1, 1, 3});
        rows.push_back('{4, 'h102, 1, 1, 1, 0, 0, -1, -1, 1, 1, 4});
        rows.push_back('{5, 'h100, 1, 0, 1, 0, 0, -1, -1, 1, 1, 5});
        rows.push_back('{6, 'h104, 2, 0, 1, 0, 0, -1, -1, 1, 1, 6});
        // Waiting loads with store-forwarded bytes
        rows.push_back('{10, 'h204, 2, 0, 0, 'b0101, 0, -1, -1, 1, 1, -1});
        rows.push_back('{11, 'h202, 1, 1, 0, 'b0010, 0, -1, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, 'h200, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, 10});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, 11});
        // Beats for other lines leave tag 12 waiting
        rows.push_back('{12, 'h300, 2, 0, 0, 0, 0, -1, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, 'h308, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, 'h1300, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, 'h300, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, 12});
        // Branch squash of stored, arriving and bypass loads
        rows.push_back('{20, 'h500, 2, 0, 1, 0, 0, -1, -1, 0, 1, -1});
        rows.push_back('{21, 'h504, 2, 0, 1, 0, 0, -1, -1, 0, 1, -1});
        rows.push_back('{22, 'h508, 1, 1, 1, 0, 1, -1, -1, 0, 1, -1});
        rows.push_back('{23, 'h50c, 2, 0, 0, 0, 0, -1, -1, 0, 1, -1});
        rows.push_back('{24, 'h510, 0, 1, 1, 0, 0, -1, 20, 0, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, 20});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, 22});
        rows.push_back('{26, 'h520, 0, 1, 1, 0, 0, -1, 30, 1, 1, 26});
        rows.push_back('{27, 'h524, 0, 0, 1, 0, 0, -1, 26, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, 'h508, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, -1});
        // Fill all entries while results are held
        for (int i = 0; i < 8; i++) begin
            low = (i % 3 == 0) ? 2'd3 : (i % 3 == 1) ? 2'd2 : 2'd0;
            rows.push_back('{40 + i, 'h400 + 4 * i + low, i % 3, i % 2, 0, 4'(i * 5), 0,
                             -1, -1, 0, 1, -1});
        end
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 0, 0, -1});
        for (int i = 0; i < 4; i++) begin
            rows.push_back('{-1, 0, 0, 0, 0, 0, 0, 'h400 + 8 * i, -1, 0, 0, -1});
        end
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 0, 0, -1});
        for (int i = 0; i < 8; i++) begin
            rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, (i == 0) ? 0 : 1, 40 + i});
        end
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, -1});
        rows.push_back('{-1, 0, 0, 0, 0, 0, 0, -1, -1, 1, 1, -1});
    endtask

    // Updates the expected state and drives one row
    task automatic applyRow(input Row r);
        logic [31:0] data;
        logic [63:0] beat;
        bit          dnc;

        data = $urandom;
        beat = {$urandom, $urandom};
        dnc = $urandom % 2;
        // A beat only completes loads stored before this cycle
        if (r.beatAddr >= 0) begin
            for (int t = 0; t < 128; t++) begin
                if (tagState[t] == tagWaiting && tagRow[t].addr[31:3] == r.beatAddr[31:3]) begin
                    tagData[t] = mergeBeat(tagData[t], tagRow[t].mask, tagRow[t].addr[2], beat);
                    expRes[t] = alignExpect(tagData[t], tagRow[t].addr[1:0], tagRow[t].size,
                                            tagRow[t].sext);
                    tagState[t] = tagLive;
                end
            end
        end
        if (r.brSqN >= 0) begin
            for (int t = 0; t < 128; t++) begin
                if ((tagState[t] == tagWaiting || (tagState[t] == tagLive && !flagsSeen[t])) &&
                    !tagRow[t].ext && isYounger(t, r.brSqN)) begin
                    tagState[t] = tagSquashed;
                end
            end
        end
        if (r.tag >= 0) begin
            tagRow[r.tag] = r;
            tagData[r.tag] = data;
            tagDnc[r.tag] = dnc;
            if (r.brSqN >= 0 && !r.ext && isYounger(r.tag, r.brSqN)) begin
                tagState[r.tag] = tagSquashed;
            end else if (r.avail) begin
                expRes[r.tag] = alignExpect(data, r.addr[1:0], r.size, r.sext);
                tagState[r.tag] = tagLive;
            end else begin
                tagState[r.tag] = tagWaiting;
            end
        end
        inValid = r.tag >= 0;
        inAddr = r.addr;
        inSize = r.size;
        inSext = r.sext;
        inDataAvail = r.avail;
        inData = data;
        inFwdMask = r.mask;
        inExternal = r.ext;
        inTagDst = r.tag;
        inSqN = r.tag + sqNBase;
        inDoNotCommit = dnc;
        fwdValid = r.beatAddr >= 0;
        fwdAddr = r.beatAddr;
        fwdData = beat;
        branchTaken = r.brSqN >= 0;
        branchSqN = r.brSqN + sqNBase;
        resReady = r.resRdy;
    endtask

    // Flags in cycle n must be followed by a result in n+1
    always @(negedge clk) begin
        if (!rst) begin
            if (resValid) begin
                if (!flagsPending) begin
                    failRun("result micro-op appeared without flags one cycle earlier");
                end
                compareValue("resTagDst", resTagDst, pendTag);
                compareValue("resResult", resResult, expRes[pendTag]);
                compareValue("resDoNotCommit", resDoNotCommit, tagDnc[pendTag]);
                resSeen[pendTag] = 1'b1;
            end else if (flagsPending) begin
                failRun($sformatf("no result micro-op followed the flags of tag %0d", pendTag));
            end
            flagsPending = flagsValid;
            if (flagsValid) begin
                if (tagState[flagsTagDst] != tagLive || flagsSeen[flagsTagDst]) begin
                    failRun($sformatf("flags for tag %0d, which is not a live load",
                                      flagsTagDst));
                end
                compareValue("flagsSqN", flagsSqN,
                             (flagsTagDst + sqNBase) % (1 << `SQN_WIDTH));
                compareValue("flagsDoNotCommit", flagsDoNotCommit, tagDnc[flagsTagDst]);
                flagsSeen[flagsTagDst] = 1'b1;
                pendTag = flagsTagDst;
            end
        end
    end

    initial begin
        wait (tableReady);
        #((rows.size() + 50) * 100);
        failRun("watchdog timeout, the run did not finish in time");
    end

    initial begin
        int missing;

        void'($urandom(52));
        rst = 1'b1;
        applyRow(idleRow(1'b0));
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            applyRow(rows[i]);
            @(negedge clk);
            if (rows[i].expReady >= 0) begin
                compareValue("ready", ready, rows[i].expReady);
            end
            if (rows[i].expFlag == -1) begin
                compareValue("flagsValid", flagsValid, 0);
            end else if (rows[i].expFlag >= 0) begin
                compareValue("flagsValid", flagsValid, 1);
                compareValue("flagsTagDst", flagsTagDst, rows[i].expFlag);
            end
        end
        repeat (3) begin
            @(posedge clk);
            #1;
            applyRow(idleRow(1'b1));
        end
        @(negedge clk);
        #1;
        missing = 0;
        for (int t = 0; t < 128; t++) begin
            if (tagState[t] == tagWaiting || (tagState[t] == tagLive && !resSeen[t])) begin
                $display("Load with tag %0d never produced a result", t);
                missing++;
            end
        end
        if (missing != 0) begin
            failRun("some loads were lost");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== loadResultUnit.f ====
+incdir+include
hdl/loadPkg.sv
hdl/loadSelIf.sv
hdl/priorityEncoder.sv
hdl/lineSnoop.sv
hdl/loadResultBuffer.sv
hdl/loadAligner.sv
hdl/loadResultUnit.sv
test/clockGen.sv
test/loadResultUnitTb.sv
